// ==== hw/arb_config.svh ====
// arbiter configuration macros for channel count, value widths and register offsets
`ifndef ARB_CONFIG_SVH
`define ARB_CONFIG_SVH

`define ARB_NCH      16     // the max-index tree is fixed at 16 inputs
`define ARB_PRIO_W   8      // base priority
`define ARB_AGE_W    4      // waiting counter, saturates at 15
`define ARB_CMP_W    9      // base plus bonus with carry

`define ARB_REG_CTRL 8'h00  // bit 0 enable, bit 1 aging
`define ARB_REG_EN   8'h04  // channel enable mask
`define ARB_REG_STAT 8'h08  // read only
`define ARB_REG_PRIO 8'h40  // channel n at 0x40 + 4n

`endif

// ==== hw/arb_pkg.sv ====
// arbiter package with the Wishbone, configuration and status types
`include "arb_config.svh"

package arb_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // busy lands on bit 12 of the status word
    typedef struct packed {
        logic       busy;
        logic [3:0] index;      // current or last grant
        logic [7:0] grant_cnt;  // wraps
    } arb_stat_t;

    typedef struct packed {
        logic                enable;
        logic                age_en;
        logic [`ARB_NCH-1:0] chan_en;
    } arb_cfg_t;

endpackage

// ==== hw/masked_max_reg.sv ====
// registered compare stage that picks the larger of two masked values
`timescale 1ns/1ps

module masked_max_reg #(
    parameter int width = 16
) (
    input  logic             clk,
    input  logic [width-1:0] i_a,
    input  logic             i_mask_a,
    input  logic [width-1:0] i_b,
    input  logic             i_mask_b,
    output logic [width-1:0] o_max,
    output logic             o_sel,
    output logic             o_valid
);

    logic pick_b;

    // b only wins when strictly greater
    assign pick_b = i_mask_b & (~i_mask_a | (i_b > i_a));

    always_ff @(posedge clk) begin
        o_max   <= pick_b ? i_b : i_a;
        o_sel   <= pick_b;
        o_valid <= i_mask_a | i_mask_b;  // either side present
    end

endmodule

// ==== hw/index_max_16.sv ====
// max-index tree that locates the largest of sixteen masked values in four cycles
`timescale 1ns/1ps

module index_max_16 #(
    parameter int width = 16
) (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic [15:0][width-1:0] i_values,
    input  logic [15:0]            i_mask,
    input  logic                   i_need,
    output logic [3:0]             o_index,
    output logic                   o_valid,
    output logic                   o_need     // i_need delayed to match o_index
);

    logic [7:0][width-1:0] max1;
    logic [7:0]            sel1;
    logic [7:0]            vld1;
    logic [3:0][width-1:0] max2;
    logic [3:0]            sel2;
    logic [3:0]            vld2;
    logic [1:0][width-1:0] max3;
    logic [1:0]            sel3;
    logic [1:0]            vld3;
    logic                  sel4;
    logic [7:0]            idx1_r;    // layer 1 selects, lined up with layer 2
    logic [3:0][1:0]       idx2_r;
    logic [1:0][2:0]       idx3_r;
    logic [3:0]            valid_dly;
    logic [3:0]            need_dly;
    logic [15:0]           mask_prev;
    logic                  mask_off;

    // a channel just dropped out, so results in flight are stale
    assign mask_off = |(~i_mask & mask_prev);

    for (genvar i = 0; i < 8; i++) begin : g_l1
        masked_max_reg #(.width(width)) u_cmp (
            .clk      (clk),
            .i_a      (i_values[2*i]),
            .i_mask_a (i_mask[2*i]),
            .i_b      (i_values[2*i+1]),
            .i_mask_b (i_mask[2*i+1]),
            .o_max    (max1[i]),
            .o_sel    (sel1[i]),
            .o_valid  (vld1[i])
        );
    end

    for (genvar i = 0; i < 4; i++) begin : g_l2
        masked_max_reg #(.width(width)) u_cmp (
            .clk      (clk),
            .i_a      (max1[2*i]),
            .i_mask_a (vld1[2*i]),
            .i_b      (max1[2*i+1]),
            .i_mask_b (vld1[2*i+1]),
            .o_max    (max2[i]),
            .o_sel    (sel2[i]),
            .o_valid  (vld2[i])
        );
    end

    for (genvar i = 0; i < 2; i++) begin : g_l3
        masked_max_reg #(.width(width)) u_cmp (
            .clk      (clk),
            .i_a      (max2[2*i]),
            .i_mask_a (vld2[2*i]),
            .i_b      (max2[2*i+1]),
            .i_mask_b (vld2[2*i+1]),
            .o_max    (max3[i]),
            .o_sel    (sel3[i]),
            .o_valid  (vld3[i])
        );
    end

    masked_max_reg #(.width(width)) u_cmp_l4 (
        .clk      (clk),
        .i_a      (max3[0]),
        .i_mask_a (vld3[0]),
        .i_b      (max3[1]),
        .i_mask_b (vld3[1]),
        .o_max    (),
        .o_sel    (sel4),
        .o_valid  ()
    );

    // index grows one bit per layer from the delayed lower selects
    always_ff @(posedge clk) begin
        idx1_r <= sel1;
        for (int j = 0; j < 4; j++) begin
            idx2_r[j] <= {sel2[j], sel2[j] ? idx1_r[2*j+1] : idx1_r[2*j]};
        end
        for (int k = 0; k < 2; k++) begin
            idx3_r[k] <= {sel3[k], sel3[k] ? idx2_r[2*k+1] : idx2_r[2*k]};
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_dly <= '0;
            need_dly  <= '0;
            mask_prev <= '0;
        end else begin
            valid_dly <= {valid_dly[2:0], |i_mask & ~mask_off};
            need_dly  <= {need_dly[2:0], i_need};
            mask_prev <= i_mask;
        end
    end

    assign o_index = {sel4, sel4 ? idx3_r[1] : idx3_r[0]};
    assign o_valid = &valid_dly;  // whole history must agree
    assign o_need  = need_dly[3];

endmodule

// ==== hw/prio_age.sv ====
// priority aging block that forms each channel's effective priority from base and wait time
`timescale 1ns/1ps
`include "arb_config.svh"

module prio_age import arb_pkg::*; (
    input  logic                                  clk,
    input  logic                                  i_reset,
    input  arb_cfg_t                              i_cfg,
    input  logic [`ARB_NCH-1:0][`ARB_PRIO_W-1:0]  i_base,
    input  logic [`ARB_NCH-1:0]                   i_req,
    input  logic [`ARB_NCH-1:0]                   i_grant,
    output logic [`ARB_NCH-1:0][`ARB_CMP_W-1:0]   o_values
);

    localparam int CMP_W = `ARB_CMP_W;

    logic [3:0]                          tick_div;   // free running
    logic                                tick;
    logic [`ARB_NCH-1:0][`ARB_AGE_W-1:0] age;
    logic [`ARB_NCH-1:0][`ARB_AGE_W-1:0] age_next;

    assign tick = &tick_div;  // once every 16 cycles

    always_comb begin
        for (int ch = 0; ch < `ARB_NCH; ch++) begin
            // only pending, enabled, ungranted channels age
            if (!i_cfg.age_en || !i_cfg.chan_en[ch] || !i_req[ch] || i_grant[ch])
                age_next[ch] = '0;
            else if (tick && age[ch] != '1)
                age_next[ch] = age[ch] + 1'b1;
            else
                age_next[ch] = age[ch];  // saturated or between ticks
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            tick_div <= '0;
            age      <= '0;
            o_values <= '0;
        end else begin
            tick_div <= tick_div + 1'b1;
            age      <= age_next;
            for (int ch = 0; ch < `ARB_NCH; ch++) begin
                o_values[ch] <= CMP_W'(i_base[ch]) + CMP_W'(age_next[ch]);
            end
        end
    end

endmodule

// ==== hw/arb_regs.sv ====
// Wishbone classic register block with arbiter control, enable mask, priorities and status
`timescale 1ns/1ps
`include "arb_config.svh"

module arb_regs import arb_pkg::*; (
    input  logic                                  clk,
    input  logic                                  i_reset,
    input  wb_req_t                               i_wb,
    input  arb_stat_t                             i_stat,
    output wb_rsp_t                               o_wb,
    output arb_cfg_t                              o_cfg,
    output logic [`ARB_NCH-1:0][`ARB_PRIO_W-1:0]  o_base
);

    localparam int NCH = `ARB_NCH;

    logic                           ack_r;
    logic [31:0]                    rdata_r;
    logic                           access;    // first cycle of a bus cycle
    logic                           ctrl_en;
    logic                           ctrl_age;
    logic [NCH-1:0]                 chan_en;
    logic [NCH-1:0][`ARB_PRIO_W-1:0] prio;
    logic                           hit_prio;
    logic [3:0]                     prio_ch;
    logic [31:0]                    rd_mux;

    assign access   = i_wb.cyc & i_wb.stb & ~ack_r;  // no second ack back to back
    assign hit_prio = i_wb.adr[7:6] == `ARB_REG_PRIO >> 6 && i_wb.adr[1:0] == 2'b00;
    assign prio_ch  = i_wb.adr[5:2];

    always_comb begin
        rd_mux = '0;  // unmapped reads as zero
        if (hit_prio) begin
            rd_mux[`ARB_PRIO_W-1:0] = prio[prio_ch];
        end else begin
            case (i_wb.adr)
                `ARB_REG_CTRL: rd_mux[1:0] = {ctrl_age, ctrl_en};
                `ARB_REG_EN:   rd_mux[NCH-1:0] = chan_en;
                `ARB_REG_STAT: rd_mux[$bits(arb_stat_t)-1:0] = i_stat;
                default:       rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ack_r    <= 1'b0;
            ctrl_en  <= 1'b0;
            ctrl_age <= 1'b0;
            chan_en  <= '1;
            prio     <= '0;
        end else begin
            ack_r <= access;
            if (access && i_wb.we) begin
                if (hit_prio) begin
                    if (i_wb.sel[0])
                        prio[prio_ch] <= i_wb.dat[`ARB_PRIO_W-1:0];
                end else if (i_wb.adr == `ARB_REG_CTRL) begin
                    ctrl_en  <= i_wb.dat[0];
                    ctrl_age <= i_wb.dat[1];
                end else if (i_wb.adr == `ARB_REG_EN) begin
                    chan_en <= i_wb.dat[NCH-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset)
            rdata_r <= '0;
        else if (access)
            rdata_r <= rd_mux;  // valid with ack
    end

    assign o_wb.ack      = ack_r;
    assign o_wb.dat      = rdata_r;
    assign o_cfg.enable  = ctrl_en;
    assign o_cfg.age_en  = ctrl_age;
    assign o_cfg.chan_en = chan_en;
    assign o_base        = prio;

endmodule

// ==== hw/grant_ctrl.sv ====
// grant controller that turns the tree result into a held one-hot grant until done
`timescale 1ns/1ps
`include "arb_config.svh"

module grant_ctrl import arb_pkg::*; (
    input  logic                clk,
    input  logic                i_reset,
    input  arb_cfg_t            i_cfg,
    input  logic [`ARB_NCH-1:0] i_req,
    input  logic                i_done,
    input  logic [3:0]          i_index,
    input  logic                i_valid,
    input  logic                i_need,
    output logic [`ARB_NCH-1:0] o_mask,
    output logic                o_need,
    output logic [`ARB_NCH-1:0] o_grant,
    output arb_stat_t           o_stat
);

    localparam int NCH = `ARB_NCH;

    logic       busy;
    logic [3:0] last_idx;
    logic [7:0] grant_cnt;
    logic       take;      // tree result accepted this cycle

    // winner must still be requesting so a stale index is never taken
    assign take   = ~busy & i_valid & i_need & i_req[i_index];
    assign o_need = |o_mask;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_mask    <= '0;
            busy      <= 1'b0;
            o_grant   <= '0;
            last_idx  <= '0;
            grant_cnt <= '0;
        end else begin
            // registered so it lines up with the effective values
            o_mask <= i_req & i_cfg.chan_en & {NCH{i_cfg.enable & ~busy & ~take}};
            if (take) begin
                busy      <= 1'b1;
                o_grant   <= NCH'(1) << i_index;
                last_idx  <= i_index;
                grant_cnt <= grant_cnt + 1'b1;  // wraps
            end else if (busy && i_done) begin
                busy    <= 1'b0;
                o_grant <= '0;
            end
        end
    end

    assign o_stat.busy      = busy;
    assign o_stat.index     = last_idx;
    assign o_stat.grant_cnt = grant_cnt;

endmodule

// ==== hw/chan_arbiter_top.sv ====
// sixteen-channel arbiter top joining registers, aging, max-index tree and grant control
`timescale 1ns/1ps
`include "arb_config.svh"

module chan_arbiter_top import arb_pkg::*; (
    input  logic                clk,
    input  logic                i_reset,
    input  wb_req_t             i_wb,
    input  logic [`ARB_NCH-1:0] i_req,
    input  logic                i_done,
    output wb_rsp_t             o_wb,
    output logic [`ARB_NCH-1:0] o_grant
);

    arb_cfg_t                            cfg;
    arb_stat_t                           stat;
    logic [`ARB_NCH-1:0][`ARB_PRIO_W-1:0] base;
    logic [`ARB_NCH-1:0][`ARB_CMP_W-1:0]  values;    // effective priorities
    logic [`ARB_NCH-1:0]                  mask;
    logic                                 need_in;
    logic                                 need_out;
    logic                                 tree_valid;
    logic [3:0]                           tree_index;

    arb_regs u_regs (
        .clk     (clk),
        .i_reset (i_reset),
        .i_wb    (i_wb),
        .i_stat  (stat),
        .o_wb    (o_wb),
        .o_cfg   (cfg),
        .o_base  (base)
    );

    prio_age u_age (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_cfg    (cfg),
        .i_base   (base),
        .i_req    (i_req),
        .i_grant  (o_grant),  // granted channels restart their wait
        .o_values (values)
    );

    index_max_16 #(.width(`ARB_CMP_W)) u_tree (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_values (values),
        .i_mask   (mask),
        .i_need   (need_in),
        .o_index  (tree_index),
        .o_valid  (tree_valid),
        .o_need   (need_out)
    );

    grant_ctrl u_grant (
        .clk     (clk),
        .i_reset (i_reset),
        .i_cfg   (cfg),
        .i_req   (i_req),
        .i_done  (i_done),
        .i_index (tree_index),
        .i_valid (tree_valid),
        .i_need  (need_out),
        .o_mask  (mask),
        .o_need  (need_in),
        .o_grant (o_grant),
        .o_stat  (stat)
    );

endmodule

// ==== dv/chan_arbiter_tb.sv ====
// testbench for the sixteen-channel arbiter with register, priority, masking, hold and aging runs
`timescale 1ns/1ps
`include "arb_config.svh"

module chan_arbiter_tb import arb_pkg::*; ();

    localparam int NROWS = 5;
    // table rows plus the hold and aging runs with 16 grants of up to 40 cycles each
    localparam longint WATCHDOG_NS = (NROWS + 2) * 16 * 40 * 10;

    logic        clk = 1'b0;
    logic        i_reset;
    wb_req_t     i_wb;
    wb_rsp_t     o_wb;
    logic [15:0] i_req;
    logic        i_done;
    logic [15:0] o_grant;

    logic [127:0] tbl_prio [NROWS];   // byte n is channel n
    logic [15:0]  tbl_req  [NROWS];
    logic [15:0]  tbl_en   [NROWS];
    logic         tbl_on   [NROWS];   // arbiter enable bit

    int value_errs  = 0;
    int other_errs  = 0;
    int grant_total = 0;              // model of the status grant counter

    chan_arbiter_top dut0 (
        .clk     (clk),
        .i_reset (i_reset),
        .i_wb    (i_wb),
        .i_req   (i_req),
        .i_done  (i_done),
        .o_wb    (o_wb),
        .o_grant (o_grant)
    );

    always #5 clk = ~clk;

    task automatic load_table();
        tbl_prio[0] = 128'h0f0e0d0c_0b0a0908_07060504_03020100;  // rising with index
        tbl_req[0]  = 16'hffff;
        tbl_en[0]   = 16'hffff;
        tbl_on[0]   = 1'b1;
        tbl_prio[1] = {16{8'h10}};                             // all tied
        tbl_req[1]  = 16'ha5a5;
        tbl_en[1]   = 16'hffff;
        tbl_on[1]   = 1'b1;
        tbl_prio[2] = 128'h30103005_7f001030_222201ff_10083010;
        tbl_req[2]  = 16'hf3ff;
        tbl_en[2]   = 16'h0fff;                                // top four masked off
        tbl_on[2]   = 1'b1;
        tbl_prio[3] = tbl_prio[0];
        tbl_req[3]  = 16'hffff;
        tbl_en[3]   = 16'hffff;
        tbl_on[3]   = 1'b0;                                    // arbiter off
        tbl_prio[4] = {$urandom, $urandom, $urandom, $urandom};
        tbl_req[4]  = 16'($urandom);
        tbl_en[4]   = 16'($urandom);
        tbl_on[4]   = 1'b1;
    endtask

    // picks the highest priority with the lowest index on ties and gives -1 when none pend
    function automatic int next_winner(input logic [127:0] prio, input logic [15:0] pending);
        int best;
        best = -1;
        for (int ch = 0; ch < `ARB_NCH; ch++) begin
            if (pending[ch] && (best < 0 || prio[8*ch +: 8] > prio[8*best +: 8]))
                best = ch;
        end
        return best;
    endfunction

    function automatic int hot_index(input logic [15:0] v);
        for (int ch = 0; ch < `ARB_NCH; ch++) begin
            if (v[ch])
                return ch;
        end
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %s: expected 0x%08h, got 0x%08h", name, exp, got);
            value_errs++;
        end
    endtask

    // one Wishbone classic access that must be acked exactly once
    task automatic bus_cycle(input wb_req_t req, output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        i_wb <= req;
        @(posedge clk);
        while (!o_wb.ack && n < 8) begin
            @(posedge clk);
            n++;
        end
        rdata = o_wb.dat;
        i_wb  <= '0;
        assert (o_wb.ack) else begin
            $display("no ack within 8 cycles for Wishbone access to 0x%02h", req.adr);
            other_errs++;
        end
        @(posedge clk);
        assert (!o_wb.ack) else begin
            $display("second ack seen for one Wishbone access to 0x%02h", req.adr);
            other_errs++;
        end
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel);
        wb_req_t     r;
        logic [31:0] unused;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = 1'b1;
        r.adr = adr;
        r.dat = dat;
        r.sel = sel;
        bus_cycle(r, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        wb_req_t r;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.adr = adr;
        r.sel = 4'hf;
        bus_cycle(r, dat);
    endtask

    task automatic program_regs(input logic [127:0] prio, input logic [15:0] en,
                                input logic [1:0] ctrl);
        for (int ch = 0; ch < `ARB_NCH; ch++) begin
            wb_write(8'(`ARB_REG_PRIO + 4 * ch), {24'b0, prio[8*ch +: 8]}, 4'hf);
        end
        wb_write(`ARB_REG_EN, {16'b0, en}, 4'hf);
        wb_write(`ARB_REG_CTRL, {30'b0, ctrl}, 4'hf);
    endtask

    task automatic wait_grant(output logic [15:0] g, output bit ok);
        ok = 1'b0;
        g  = '0;
        for (int n = 0; n < 12 && !ok; n++) begin
            @(posedge clk);
            if (o_grant != '0) begin
                ok = 1'b1;
                g  = o_grant;
            end
        end
        assert (ok) else begin
            $display("no grant appeared within 12 cycles");
            other_errs++;
        end
    endtask

    task automatic pulse_done(input int ch, input bit rearm);
        @(posedge clk);
        i_done    <= 1'b1;
        i_req[ch] <= 1'b0;  // request drops with done
        @(posedge clk);
        i_done <= 1'b0;
        if (rearm)
            i_req[ch] <= 1'b1;
    endtask

    // wait for one grant, check it and the status word, hold it, then release
    task automatic serve_grant(input int exp_ch, input logic [15:0] late_req);
        logic [15:0] g;
        bit          ok;
        logic [31:0] stat;
        int          hold;
        wait_grant(g, ok);
        if (!ok)
            return;
        grant_total++;
        check_value("o_grant", g, 16'(1) << exp_ch);
        if (late_req != '0)
            i_req <= i_req | late_req;  // arrives while the grant is held
        wb_read(`ARB_REG_STAT, stat);
        check_value("status", stat, {19'b0, 1'b1, 4'(exp_ch), 8'(grant_total)});
        hold = 1 + $urandom % 8;
        repeat (hold) begin
            @(posedge clk);
            check_value("o_grant", o_grant, g);
        end
        pulse_done(hot_index(g), 1'b0);
    endtask

    task automatic idle_check(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            check_value("o_grant", o_grant, 32'h0);
        end
    endtask

    task automatic reg_test();
        logic [31:0] d;
        wb_read(`ARB_REG_STAT, d);
        check_value("status", d, 32'h0);
        wb_read(`ARB_REG_EN, d);
        check_value("chan_en", d, 32'h0000_ffff);
        wb_write(`ARB_REG_CTRL, 32'h3, 4'hf);
        wb_read(`ARB_REG_CTRL, d);
        check_value("ctrl", d, 32'h3);
        wb_write(`ARB_REG_CTRL, 32'h0, 4'hf);
        wb_write(`ARB_REG_EN, 32'hdead_5a3c, 4'hf);
        wb_read(`ARB_REG_EN, d);
        check_value("chan_en", d, 32'h0000_5a3c);  // only 16 bits held
        wb_write(8'(`ARB_REG_PRIO + 4 * 7), 32'h0000_00a5, 4'hf);
        wb_read(8'(`ARB_REG_PRIO + 4 * 7), d);
        check_value("prio7", d, 32'ha5);
        wb_write(8'(`ARB_REG_PRIO + 4 * 7), 32'h11, 4'h0);  // byte 0 not selected
        wb_read(8'(`ARB_REG_PRIO + 4 * 7), d);
        check_value("prio7", d, 32'ha5);
        wb_write(8'h30, 32'hffff_ffff, 4'hf);
        wb_read(8'h30, d);
        check_value("unmapped", d, 32'h0);
        wb_read(8'h0c, d);
        check_value("unmapped", d, 32'h0);
    endtask

    task automatic run_row(input int r);
        logic [15:0] pending;
        int          exp_ch;
        program_regs(tbl_prio[r], tbl_en[r], {1'b0, tbl_on[r]});
        pending = tbl_on[r] ? (tbl_req[r] & tbl_en[r]) : 16'h0;
        @(posedge clk);
        i_req <= tbl_req[r];
        for (int k = 0; k < `ARB_NCH; k++) begin
            exp_ch = next_winner(tbl_prio[r], pending);
            if (exp_ch < 0)
                break;
            serve_grant(exp_ch, 16'h0);
            pending[exp_ch] = 1'b0;
        end
        idle_check(30);  // masked or non-requesting channels stay out
        @(posedge clk);
        i_req <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic hold_test();
        logic [127:0] prio;
        prio          = '0;
        prio[8*2 +: 8] = 8'h01;
        prio[8*9 +: 8] = 8'hc8;
        program_regs(prio, 16'hffff, 2'b01);
        @(posedge clk);
        i_req <= 16'h0004;
        serve_grant(2, 16'h0200);  // higher priority shows up mid-grant
        serve_grant(9, 16'h0);
        idle_check(10);
    endtask

    task automatic aging_test();
        logic [127:0] prio;
        logic [15:0]  g;
        bit           ok;
        bit           found;
        prio = '0;
        for (int ch = 1; ch <= 3; ch++)
            prio[8*ch +: 8] = 8'h05;
        program_regs(prio, 16'hffff, 2'b11);
        @(posedge clk);
        i_req <= 16'h000f;
        found = 1'b0;
        for (int n = 0; n < 20 && !found; n++) begin
            wait_grant(g, ok);
            if (!ok)
                break;
            grant_total++;
            assert ($onehot(g) && (g & 16'hfff0) == '0) else begin
                $display("FAIL o_grant: expected one-hot within 0x000f, got 0x%04h", g);
                value_errs++;
            end
            found = g[0];
            repeat (1 + $urandom % 8) @(posedge clk);
            pulse_done(hot_index(g), !g[0]);  // channels 1 to 3 come straight back
        end
        assert (found) else begin
            $display("channel 0 was not granted within 20 grants with aging on");
            other_errs++;
        end
        @(posedge clk);
        i_req <= '0;
        idle_check(10);
        wb_write(`ARB_REG_CTRL, 32'h0, 4'hf);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        i_reset = 1'b1;
        i_wb    = '0;
        i_req   = '0;
        i_done  = 1'b0;
        void'($urandom(54708));
        load_table();
        repeat (10) @(posedge clk);
        i_reset <= 1'b0;
        repeat (2) @(posedge clk);
        reg_test();
        for (int r = 0; r < NROWS; r++)
            run_row(r);
        hold_test();
        aging_test();
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hw
hw/arb_pkg.sv
hw/masked_max_reg.sv
hw/index_max_16.sv
hw/prio_age.sv
hw/arb_regs.sv
hw/grant_ctrl.sv
hw/chan_arbiter_top.sv
dv/chan_arbiter_tb.sv

// ==== Bender.yml ====
package:
  name: chan_arbiter

sources:
  - include_dirs:
      - hw
    files:
      - hw/arb_pkg.sv
      - hw/masked_max_reg.sv
      - hw/index_max_16.sv
      - hw/prio_age.sv
      - hw/arb_regs.sv
      - hw/grant_ctrl.sv
      - hw/chan_arbiter_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/chan_arbiter_tb.sv
